//--- Makefile
# Verilator build and run of the timer testbench

TOP = frc_timer_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f frc_timer.f -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/frc_timer_props.sv
// Timer assertions on run state and interrupt behavior, bound into the FSM and registers
`timescale 1ns/1ps

module frc_timer_props (
  input logic       PCLK,
  input logic       PRESETn,
  input logic [1:0] state,
  input logic       run,
  input logic       frc_int,
  input logic       int_enable,
  input logic       wrap,
  input logic       raw_int
);

  // Counting only allowed in RUN
  a_run_only_in_run: assert property (
    @(posedge PCLK) disable iff (!PRESETn)
    (state == frc_count_pkg::IDLE || state == frc_count_pkg::HALT) |-> !run
  ) else $error("run high outside the RUN state");

  // Output interrupt is masked by int_enable
  a_int_masked: assert property (
    @(posedge PCLK) disable iff (!PRESETn)
    frc_int |-> int_enable
  ) else $error("frc_int high with int_enable clear");

  // Raw interrupt one cycle after a wrap
  a_wrap_sets_raw: assert property (
    @(posedge PCLK) disable iff (!PRESETn)
    wrap |=> raw_int
  ) else $error("raw interrupt not set after a wrap");

endmodule

// FSM instances only drive the state checks
bind frc_run_fsm frc_timer_props i_fsm_props (
  .PCLK       (PCLK),
  .PRESETn    (PRESETn),
  .state      (state),
  .run        (run),
  .frc_int    (1'b0),
  .int_enable (1'b0),
  .wrap       (1'b0),
  .raw_int    (1'b0)
);

// Register instances only drive the interrupt checks
bind frc_apb_regs frc_timer_props i_regs_props (
  .PCLK       (PCLK),
  .PRESETn    (PRESETn),
  .state      (frc_count_pkg::RUN),
  .run        (1'b1),
  .frc_int    (frc_int),
  .int_enable (ctrl.int_enable),
  .wrap       (status.wrap),
  .raw_int    (raw_int)
);

//--- bench/frc_timer_tb.sv
// Timer testbench that applies a table of load, mode and prescale cases over APB
`timescale 1ns/1ps

module frc_timer_tb;

  // PCLK period in ns
  localparam int CLK_PERIOD = 8;

  // One case of the table with its expected fields
  typedef struct {
    string       name;
    logic [7:0]  ctrl;
    logic [31:0] load;
    logic        use_bg;
    logic [31:0] bg;
    logic        half;
    int          cycles;
    logic [31:0] exp_value;
    logic [31:0] exp_period;
    logic        exp_ris;
    logic        exp_int;
  } row_t;

  // DUT ports
  logic        PCLK;
  logic        PRESETn;
  logic        PSEL;
  logic        PENABLE;
  logic [4:2]  PADDR;
  logic        PWRITE;
  logic [31:0] PWDATA;
  logic        TIMCLKEN;
  logic [31:0] PRDATA;
  logic        frc_int;

  // Table and bookkeeping
  row_t        rows[$];
  string       cur_test;
  logic [31:0] strobe_value;
  int          errors;
  int          checks;
  int          test_errors;
  int          tests;

  frc_timer i_dut (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .PSEL     (PSEL),
    .PENABLE  (PENABLE),
    .PADDR    (PADDR),
    .PWRITE   (PWRITE),
    .PWDATA   (PWDATA),
    .TIMCLKEN (TIMCLKEN),
    .PRDATA   (PRDATA),
    .frc_int  (frc_int)
  );

  initial
  begin
    PCLK = 1'b0;
    forever #(CLK_PERIOD / 2) PCLK = ~PCLK;
  end

  // --------------------------------------------------------------------------
  // Checks and reference model
  // --------------------------------------------------------------------------

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      test_errors++;
      $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
    end
  endtask

  // Steps the count through the zero rules of the three modes
  function automatic void model_count(input logic [7:0] ctrl, input logic [31:0] start,
                                      input logic [31:0] period, input int steps,
                                      output logic [31:0] value, output logic wrapped);
    logic halted;
    int   i;
    value   = start;
    wrapped = 1'b0;
    halted  = 1'b0;
    for (i = 0; i < steps; i++)
    begin
      if (!halted)
      begin
        if (value != 32'h0)
          value = value - 32'h1;
        else
        begin
          wrapped = 1'b1;
          // One-shot stops at zero, periodic reloads, free-running rolls over
          if (ctrl[0])
            halted = 1'b1;
          else if (ctrl[6])
            value = period;
          else
            value = 32'hFFFF_FFFF;
        end
      end
    end
  endfunction

  task automatic add_row(input string name, input logic [7:0] ctrl, input logic [31:0] load,
                         input logic rnd, input logic use_bg, input logic [31:0] bg,
                         input logic half, input int cycles);
    row_t r;
    int   pulses;
    int   steps;
    r.name   = name;
    r.ctrl   = ctrl;
    r.load   = rnd ? $urandom : load;
    r.use_bg = use_bg;
    r.bg     = bg;
    r.half   = half;
    r.cycles = cycles;
    // Background load replaces only the reload period
    r.exp_period = use_bg ? bg : r.load;
    // Every other cycle starts high, so an odd count gets the extra pulse
    pulses = half ? (cycles + 1) / 2 : cycles;
    case (ctrl[3:2])
      2'd0:    steps = pulses;
      2'd1:    steps = pulses / 16;
      default: steps = pulses / 256;
    endcase
    model_count(ctrl, r.load, r.exp_period, steps, r.exp_value, r.exp_ris);
    r.exp_int = r.exp_ris & ctrl[5];
    rows.push_back(r);
  endtask

  // --------------------------------------------------------------------------
  // Bus and timer stimulus
  // --------------------------------------------------------------------------

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    @(negedge PCLK);
    PSEL    = 1'b1;
    PWRITE  = 1'b1;
    PENABLE = 1'b0;
    PADDR   = addr;
    PWDATA  = data;
    @(negedge PCLK);
    PENABLE = 1'b1;
    // Access phase of a load write is the strobe cycle
    #(CLK_PERIOD / 4);
    if (addr == frc_regs_pkg::ADDR_LOAD)
      strobe_value = i_dut.status.value;
    @(negedge PCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
    @(negedge PCLK);
    PSEL    = 1'b1;
    PWRITE  = 1'b0;
    PENABLE = 1'b0;
    PADDR   = addr;
    @(negedge PCLK);
    PENABLE = 1'b1;
    #(CLK_PERIOD / 4);
    data = PRDATA;
    @(negedge PCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  // TIMCLKEN is low outside this window so nothing counts during bus traffic
  task automatic clock_timer(input int cycles, input logic half);
    int i;
    for (i = 0; i < cycles; i++)
    begin
      @(negedge PCLK);
      TIMCLKEN = half ? (i % 2 == 0) : 1'b1;
    end
    @(negedge PCLK);
    TIMCLKEN = 1'b0;
  endtask

  task automatic wait_for_int(input int limit);
    int n;
    n = 0;
    while (frc_int !== 1'b1 && n < limit)
    begin
      @(negedge PCLK);
      n++;
    end
    if (frc_int !== 1'b1)
    begin
      errors++;
      test_errors++;
      $display("Timeout in %s: frc_int did not go high within %0d cycles", cur_test, limit);
    end
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0] data;
    cur_test    = r.name;
    test_errors = 0;
    // Enable first so the load lands on a running counter
    write_reg(frc_regs_pkg::ADDR_CONTROL, {24'h0, r.ctrl});
    write_reg(frc_regs_pkg::ADDR_INTCLR, 32'h1);
    write_reg(frc_regs_pkg::ADDR_LOAD, r.load);
    compare_value("strobe value", r.load, strobe_value);
    if (r.use_bg)
      write_reg(frc_regs_pkg::ADDR_BGLOAD, r.bg);
    clock_timer(r.cycles, r.half);
    if (r.exp_int)
      wait_for_int(16);
    read_reg(frc_regs_pkg::ADDR_VALUE, data);
    compare_value("value", r.exp_value, data);
    read_reg(frc_regs_pkg::ADDR_LOAD, data);
    compare_value("load readback", r.exp_period, data);
    read_reg(frc_regs_pkg::ADDR_RIS, data);
    compare_value("raw status", {31'h0, r.exp_ris}, data);
    read_reg(frc_regs_pkg::ADDR_MIS, data);
    compare_value("masked status", {31'h0, r.exp_int}, data);
    compare_value("frc_int", {31'h0, r.exp_int}, {31'h0, frc_int});
    // Clear drops both status bits
    write_reg(frc_regs_pkg::ADDR_INTCLR, 32'h1);
    read_reg(frc_regs_pkg::ADDR_RIS, data);
    compare_value("raw after clear", 32'h0, data);
    read_reg(frc_regs_pkg::ADDR_MIS, data);
    compare_value("masked after clear", 32'h0, data);
    compare_value("frc_int after clear", 32'h0, {31'h0, frc_int});
    tests++;
    if (test_errors == 0)
      $display("Test %-16s ok", r.name);
    else
      $display("Test %-16s %0d error(s)", r.name, test_errors);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial
  begin
    logic [31:0] data;
    int          i;
    PRESETn  = 1'b0;
    PSEL     = 1'b0;
    PENABLE  = 1'b0;
    PADDR    = 3'd0;
    PWRITE   = 1'b0;
    PWDATA   = 32'h0;
    TIMCLKEN = 1'b0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    void'($urandom(32'h74eb_efca));

    // Name, control, load, random, background, bg value, half rate, cycles
    add_row("div1_full",   8'hA0, 32'd1000, 1'b0, 1'b0, 32'd0,   1'b0, 40);
    add_row("div1_half",   8'hA0, 32'd1000, 1'b0, 1'b0, 32'd0,   1'b1, 40);
    add_row("div1_random", 8'hA0, 32'd0,    1'b1, 1'b0, 32'd0,   1'b0, 25);
    add_row("div16",       8'hA4, 32'd500,  1'b0, 1'b0, 32'd0,   1'b0, 100);
    add_row("div16_half",  8'hA4, 32'd300,  1'b0, 1'b0, 32'd0,   1'b1, 70);
    add_row("div256_rand", 8'hA8, 32'd0,    1'b1, 1'b0, 32'd0,   1'b0, 600);
    add_row("periodic_bg", 8'hE0, 32'd5,    1'b0, 1'b1, 32'd100, 1'b0, 20);
    add_row("oneshot_stop", 8'hA1, 32'd5,   1'b0, 1'b0, 32'd0,   1'b0, 20);
    add_row("oneshot_again", 8'hA1, 32'd30, 1'b0, 1'b0, 32'd0,   1'b0, 10);
    add_row("free_wrap",   8'hA0, 32'd3,    1'b0, 1'b0, 32'd0,   1'b0, 4);
    add_row("int_masked",  8'hC0, 32'd2,    1'b0, 1'b0, 32'd0,   1'b0, 10);

    // Reset held for 5 clock cycles
    repeat (5) @(posedge PCLK);
    @(negedge PCLK);
    PRESETn = 1'b1;

    cur_test    = "reset";
    test_errors = 0;
    // Only the interrupt enable is set out of reset
    read_reg(frc_regs_pkg::ADDR_CONTROL, data);
    compare_value("control", 32'h0000_0020, data);
    read_reg(frc_regs_pkg::ADDR_VALUE, data);
    compare_value("value", 32'hFFFF_FFFF, data);
    read_reg(frc_regs_pkg::ADDR_LOAD, data);
    compare_value("load", 32'h0, data);
    compare_value("frc_int", 32'h0, {31'h0, frc_int});
    tests++;
    if (test_errors == 0)
      $display("Test %-16s ok", cur_test);
    else
      $display("Test %-16s %0d error(s)", cur_test, test_errors);

    for (i = 0; i < rows.size(); i++)
      apply_row(rows[i]);

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- frc_timer.f
hdl/frc_count_pkg.sv
hdl/frc_regs_pkg.sv
hdl/frc_apb_regs.sv
hdl/frc_prescaler.sv
hdl/frc_run_fsm.sv
hdl/frc_down_counter.sv
hdl/frc_timer.sv
bench/frc_timer_props.sv
bench/frc_timer_tb.sv

//--- hdl/frc_apb_regs.sv
// Timer APB register block with control, load, period, interrupt latch and read mux
`timescale 1ns/1ps

module frc_apb_regs (
  input  logic                       PCLK,
  input  logic                       PRESETn,
  input  logic                       PSEL,
  input  logic                       PENABLE,
  input  logic [4:2]                 PADDR,
  input  logic                       PWRITE,
  input  logic [31:0]                PWDATA,
  input  frc_count_pkg::frc_cnt_st_t status,
  output frc_regs_pkg::frc_ctrl_t    ctrl,
  output frc_regs_pkg::frc_cmd_t     cmd,
  output logic [31:0]                PRDATA,
  output logic                       frc_int
);

  // Write decode
  logic wr_setup;
  logic ctrl_en;
  logic load_en;
  logic bg_en;
  logic clr_en;

  // Register state
  logic        load_pend;
  logic [31:0] load_val;
  logic [31:0] period;
  logic        raw_int;

  // --------------------------------------------------------------------------
  // Write decode in the APB setup phase
  // --------------------------------------------------------------------------

  assign wr_setup = PSEL & PWRITE & ~PENABLE;
  assign ctrl_en  = wr_setup & (PADDR == frc_regs_pkg::ADDR_CONTROL);
  assign load_en  = wr_setup & (PADDR == frc_regs_pkg::ADDR_LOAD);
  assign bg_en    = wr_setup & (PADDR == frc_regs_pkg::ADDR_BGLOAD);
  assign clr_en   = wr_setup & (PADDR == frc_regs_pkg::ADDR_INTCLR);

  // --------------------------------------------------------------------------
  // Control, load and period registers
  // --------------------------------------------------------------------------

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      // Fields taken from the control reset value
      ctrl.enable     <= frc_regs_pkg::CTRL_RESET[7];
      ctrl.periodic   <= frc_regs_pkg::CTRL_RESET[6];
      ctrl.int_enable <= frc_regs_pkg::CTRL_RESET[5];
      ctrl.prescale   <= frc_regs_pkg::CTRL_RESET[3:2];
      ctrl.one_shot   <= frc_regs_pkg::CTRL_RESET[0];
      load_pend       <= 1'b0;
      period          <= '0;
    end
    else
    begin
      if (ctrl_en)
      begin
        ctrl.enable     <= PWDATA[7];
        ctrl.periodic   <= PWDATA[6];
        ctrl.int_enable <= PWDATA[5];
        ctrl.prescale   <= PWDATA[3:2];
        ctrl.one_shot   <= PWDATA[0];
      end
      // Strobe for exactly the cycle after the setup phase
      load_pend <= load_en;
      // Both load addresses set the reload period
      if (load_en | bg_en)
        period <= PWDATA;
    end
  end

  // Load value handed to the counter with the strobe
  always_ff @(posedge PCLK)
  begin
    if (load_en)
      load_val <= PWDATA;
  end

  always_comb
  begin
    cmd.load     = load_pend;
    cmd.load_val = load_val;
    cmd.period   = period;
  end

  // --------------------------------------------------------------------------
  // Interrupt latch
  // --------------------------------------------------------------------------

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
      raw_int <= 1'b0;
    else if (status.wrap)
      raw_int <= 1'b1;   // a wrap beats a clear in the same cycle
    else if (clr_en)
      raw_int <= 1'b0;
  end

  // Masked interrupt with no extra register stage
  assign frc_int = raw_int & ctrl.int_enable;

  // --------------------------------------------------------------------------
  // Read data
  // --------------------------------------------------------------------------

  always_comb
  begin
    PRDATA = '0;
    if (PSEL && !PWRITE)
    begin
      case (PADDR)
        frc_regs_pkg::ADDR_LOAD:    PRDATA = period;
        frc_regs_pkg::ADDR_VALUE:   PRDATA = status.value;
        frc_regs_pkg::ADDR_CONTROL:
          PRDATA[7:0] = {ctrl.enable, ctrl.periodic, ctrl.int_enable, 1'b0,
                         ctrl.prescale, 1'b0, ctrl.one_shot};
        frc_regs_pkg::ADDR_RIS:     PRDATA[0] = raw_int;
        frc_regs_pkg::ADDR_MIS:     PRDATA[0] = frc_int;
        frc_regs_pkg::ADDR_BGLOAD:  PRDATA = period;
        // Clear register and unmapped words read zero
        default:                    PRDATA = '0;
      endcase
    end
  end

endmodule

//--- hdl/frc_count_pkg.sv
// Timer count package with count widths, prescale codes, run states and counter status
package frc_count_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  // Main down counter
  localparam int COUNT_W = 32;

  // Prescale counter
  localparam int PRE_W = 8;

  // --------------------------------------------------------------------------
  // Prescale select codes
  // --------------------------------------------------------------------------

  localparam logic [1:0] PRE_DIV1   = 2'd0;
  localparam logic [1:0] PRE_DIV16  = 2'd1;
  localparam logic [1:0] PRE_DIV256 = 2'd2;
  // Code 3 is unassigned and behaves as divide by 256

  // Run state of the counter
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    HALT = 2'd2
  } frc_run_e;

  // Counter status back to the registers
  // wrap pulses for one cycle when the count passes zero
  typedef struct packed {
    logic               wrap;
    logic [COUNT_W-1:0] value;
  } frc_cnt_st_t;

endpackage

//--- hdl/frc_down_counter.sv
// Timer 32-bit down counter with load, periodic reload and zero detection
`timescale 1ns/1ps

module frc_down_counter (
  input  logic                       PCLK,
  input  logic                       PRESETn,
  input  logic                       TIMCLKEN,
  input  logic                       tick,
  input  logic                       run,
  input  frc_regs_pkg::frc_ctrl_t    ctrl,
  input  frc_regs_pkg::frc_cmd_t     cmd,
  output frc_count_pkg::frc_cnt_st_t status
);

  // Current count
  logic [frc_count_pkg::COUNT_W-1:0] count;
  logic [frc_count_pkg::COUNT_W-1:0] count_nxt;

  // Decrement qualifier and zero detect
  logic dec_due;
  logic at_zero;
  logic wrap;

  assign dec_due = TIMCLKEN & tick & run;
  assign at_zero = (count == '0);
  // Load suppresses the wrap of the old count
  assign wrap    = dec_due & at_zero & ~cmd.load;

  // --------------------------------------------------------------------------
  // Next count
  // --------------------------------------------------------------------------

  always_comb
  begin
    count_nxt = count;
    if (cmd.load)
      count_nxt = cmd.load_val;
    else if (dec_due)
    begin
      if (!at_zero)
        count_nxt = count - 1'b1;
      // Zero rule per mode
      else if (ctrl.one_shot)
        count_nxt = '0;
      else if (ctrl.periodic)
        count_nxt = cmd.period;
      else
        count_nxt = '1;
    end
  end

  // --------------------------------------------------------------------------
  // Count register
  // --------------------------------------------------------------------------

  // All ones at reset keeps the counter far from a wrap
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
      count <= '1;
    else
      count <= count_nxt;
  end

  // --------------------------------------------------------------------------
  // Status
  // --------------------------------------------------------------------------

  // New load value is visible while the strobe is high
  always_comb
  begin
    status.wrap  = wrap;
    status.value = cmd.load ? cmd.load_val : count;
  end

endmodule

//--- hdl/frc_prescaler.sv
// Timer prescaler dividing TIMCLKEN by 1, 16 or 256 into the count tick
`timescale 1ns/1ps

module frc_prescaler (
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  logic                    TIMCLKEN,
  input  frc_regs_pkg::frc_ctrl_t ctrl,
  input  frc_regs_pkg::frc_cmd_t  cmd,
  output logic                    tick
);

  // Prescale counter and its divider taps
  logic [frc_count_pkg::PRE_W-1:0] pre_cnt;
  logic                            en_16;
  logic                            en_256;
  logic                            pre_sel;

  // --------------------------------------------------------------------------
  // Prescale counter
  // --------------------------------------------------------------------------

  // Load clears it so the first period after a load is a full one
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
      pre_cnt <= '0;
    else if (cmd.load)
      pre_cnt <= '0;
    else if (TIMCLKEN && ctrl.enable)
      pre_cnt <= pre_cnt - 1'b1;
  end

  // --------------------------------------------------------------------------
  // Tick select
  // --------------------------------------------------------------------------

  // Low nibble at one marks every 16th step
  assign en_16  = (pre_cnt[3:0] == 4'h1);
  // Full byte at one marks every 256th step
  assign en_256 = (pre_cnt == 8'h01);

  always_comb
  begin
    case (ctrl.prescale)
      frc_count_pkg::PRE_DIV1:   pre_sel = 1'b1;
      frc_count_pkg::PRE_DIV16:  pre_sel = en_16;
      frc_count_pkg::PRE_DIV256: pre_sel = en_256;
      default:                   pre_sel = en_256;
    endcase
  end

  // Only on qualified timer steps
  assign tick = TIMCLKEN & ctrl.enable & pre_sel;

endmodule

//--- hdl/frc_regs_pkg.sv
// Timer register package with the APB register map, control fields and command struct
package frc_regs_pkg;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------

  // Word addresses on PADDR[4:2]
  localparam logic [2:0] ADDR_LOAD    = 3'd0;
  localparam logic [2:0] ADDR_VALUE   = 3'd1;
  localparam logic [2:0] ADDR_CONTROL = 3'd2;
  localparam logic [2:0] ADDR_INTCLR  = 3'd3;
  localparam logic [2:0] ADDR_RIS     = 3'd4;
  localparam logic [2:0] ADDR_MIS     = 3'd5;
  localparam logic [2:0] ADDR_BGLOAD  = 3'd6;

  // Control reset value with only the interrupt enable set
  localparam logic [7:0] CTRL_RESET = 8'h20;

  // --------------------------------------------------------------------------
  // Control fields
  // --------------------------------------------------------------------------

  // Read-back positions
  // enable 7, periodic 6, int_enable 5, prescale 3:2, one_shot 0
  // Bit 1 (counter size) is not kept and reads as zero
  typedef struct packed {
    logic       enable;
    logic       periodic;
    logic       int_enable;
    logic [1:0] prescale;
    logic       one_shot;
  } frc_ctrl_t;

  // --------------------------------------------------------------------------
  // Register to counter command
  // --------------------------------------------------------------------------

  // Load strobe is high for one cycle after a load write
  // The period is the value used when a periodic count wraps
  typedef struct packed {
    logic                               load;
    logic [frc_count_pkg::COUNT_W-1:0] load_val;
    logic [frc_count_pkg::COUNT_W-1:0] period;
  } frc_cmd_t;

endpackage

//--- hdl/frc_run_fsm.sv
// Timer run FSM deciding when the down counter may count
`timescale 1ns/1ps

module frc_run_fsm (
  input  logic                       PCLK,
  input  logic                       PRESETn,
  input  frc_regs_pkg::frc_ctrl_t    ctrl,
  input  frc_regs_pkg::frc_cmd_t     cmd,
  input  frc_count_pkg::frc_cnt_st_t status,
  output logic                       run
);

  frc_count_pkg::frc_run_e state;
  frc_count_pkg::frc_run_e state_nxt;

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------

  always_comb
  begin
    state_nxt = state;
    case (state)
      frc_count_pkg::IDLE:
        if (ctrl.enable)
          state_nxt = frc_count_pkg::RUN;
      frc_count_pkg::RUN:
        // Disable has priority over the one-shot stop
        if (!ctrl.enable)
          state_nxt = frc_count_pkg::IDLE;
        else if (status.wrap && ctrl.one_shot)
          state_nxt = frc_count_pkg::HALT;
      frc_count_pkg::HALT:
        if (!ctrl.enable)
          state_nxt = frc_count_pkg::IDLE;
        // New load or leaving one-shot mode restarts the count
        else if (cmd.load || !ctrl.one_shot)
          state_nxt = frc_count_pkg::RUN;
      default:
        state_nxt = frc_count_pkg::IDLE;
    endcase
  end

  // --------------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------------

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
      state <= frc_count_pkg::IDLE;
    else
      state <= state_nxt;
  end

  // Count permission
  assign run = (state == frc_count_pkg::RUN);

endmodule

//--- hdl/frc_timer.sv
// Single-channel APB down-counting timer top level
`timescale 1ns/1ps

module frc_timer (
  input  logic        PCLK,
  input  logic        PRESETn,
  input  logic        PSEL,
  input  logic        PENABLE,
  input  logic [4:2]  PADDR,
  input  logic        PWRITE,
  input  logic [31:0] PWDATA,
  input  logic        TIMCLKEN,
  output logic [31:0] PRDATA,
  output logic        frc_int
);

  // Control fields to every block
  frc_regs_pkg::frc_ctrl_t    ctrl;
  // Load strobe, load value and period
  frc_regs_pkg::frc_cmd_t     cmd;
  // Counter wrap and value back to the registers
  frc_count_pkg::frc_cnt_st_t status;
  logic                       tick;
  logic                       run;

  // --------------------------------------------------------------------------
  // APB registers
  // --------------------------------------------------------------------------

  frc_apb_regs i_regs (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PADDR   (PADDR),
    .PWRITE  (PWRITE),
    .PWDATA  (PWDATA),
    .status  (status),
    .ctrl    (ctrl),
    .cmd     (cmd),
    .PRDATA  (PRDATA),
    .frc_int (frc_int)
  );

  // --------------------------------------------------------------------------
  // Count path
  // --------------------------------------------------------------------------

  frc_prescaler i_prescaler (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .TIMCLKEN (TIMCLKEN),
    .ctrl     (ctrl),
    .cmd      (cmd),
    .tick     (tick)
  );

  frc_run_fsm i_run_fsm (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .ctrl    (ctrl),
    .cmd     (cmd),
    .status  (status),
    .run     (run)
  );

  frc_down_counter i_counter (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .TIMCLKEN (TIMCLKEN),
    .tick     (tick),
    .run      (run),
    .ctrl     (ctrl),
    .cmd      (cmd),
    .status   (status)
  );

endmodule
